// File: Bender.yml
package:
  name: flow_table

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/flow_table_pkg.sv
      - rtl/flow_hash.sv
      - rtl/flow_bank.sv
      - rtl/flow_lookup.sv
      - rtl/flow_place_fsm.sv
      - rtl/flow_table_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/flow_table_checker.sv
      - tests/flow_table_monitor.sv
      - tests/flow_table_tb.sv

// File: compile.f
+incdir+rtl
rtl/flow_table_pkg.sv
rtl/flow_hash.sv
rtl/flow_bank.sv
rtl/flow_lookup.sv
rtl/flow_place_fsm.sv
rtl/flow_table_top.sv
tests/flow_table_checker.sv
tests/flow_table_monitor.sv
tests/flow_table_tb.sv

// File: rtl/flow_bank.sv
`timescale 1ns/1ps
`default_nettype none

module flow_bank
    import flow_table_pkg::*;
#(
    parameter int AWIDTH = 4,
    parameter int DEPTH  = 16
) (
    input  wire              clk,
    input  wire [AWIDTH-1:0] addr_a,
    input  wire              rden_a,
    input  wire              en_a,
    output fce_t             q_a,
    input  wire [AWIDTH-1:0] addr_b,
    input  wire              rden_b,
    input  wire              wren_b,
    input  var fce_t         data_b,
    output fce_t             q_b
);

    fce_t              mem [DEPTH];
    logic [AWIDTH-1:0] addr_a_r;
    logic [AWIDTH-1:0] addr_b_r;
    logic              rden_a_r;
    logic              rden_b_r;

    // All entries start out invalid.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Lookup port, frozen together with the lookup pipeline.
    always_ff @(posedge clk) begin
        if (en_a) begin
            addr_a_r <= addr_a;
            rden_a_r <= rden_a;
            if (rden_a_r) begin
                q_a <= mem[addr_a_r];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_b_r <= addr_b;
        rden_b_r <= rden_b;
        if (rden_b_r) begin
            q_b <= mem[addr_b_r];
        end
    end

    always @(posedge clk) begin
        if (wren_b) begin
            mem[addr_b] <= data_b;
        end
    end

endmodule

`default_nettype wire

// File: rtl/flow_hash.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_table_defs.svh"

module flow_hash
    import flow_table_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,
    input  wire [`FT_TUPLE_W-1:0] tuple,
    input  wire                   tuple_valid,
    output bank_idx_t             idx,
    output logic                  idx_valid
);

    bank_idx_t idx_next;

    // Seeded multiply; index is the top bits of the 32-bit product.
    function automatic logic [`FT_AWIDTH-1:0] bank_hash(input logic [31:0] t,
                                                        input int unsigned bank);
        logic [31:0] seed;
        logic [31:0] mixed;
        seed  = 32'(bank) * `FT_SEED_STEP;
        mixed = (t ^ seed) * `FT_HASH_MULT;
        return mixed[31 -: `FT_AWIDTH];
    endfunction

    always_comb begin
        for (int i = 0; i < `FT_BANKS; i++) begin
            idx_next[i] = bank_hash(32'(tuple), i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_valid <= 1'b0;
        end else if (!stall) begin
            idx_valid <= tuple_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idx <= idx_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/flow_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_table_defs.svh"

module flow_lookup
    import flow_table_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  var meta_t meta_in,
    input  wire       meta_in_valid,
    output logic      meta_in_ready,
    output meta_t     meta_out,
    output logic      meta_out_valid,
    input  wire       meta_out_ready,
    output bank_idx_t bank_addr,
    output logic      bank_rden,
    output logic      bank_en,
    input  var fce_t  bank_q [`FT_BANKS]
);

    logic                 stall;
    logic                 accept;
    meta_t                meta_s0;
    meta_t                meta_s1;
    meta_t                meta_s2;
    logic                 valid_s1;
    logic                 valid_s2;
    logic [`FT_BANKS-1:0] hit;
    logic [`FT_QID_W-1:0] qid_sel;

    // Whole pipeline moves only when the sink can take a result.
    assign stall         = !meta_out_ready;
    assign meta_in_ready = meta_out_ready;
    assign accept        = meta_in_valid && meta_in_ready;
    assign bank_en       = !stall;

    flow_hash u_hash (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .tuple       (meta_in.tuple),
        .tuple_valid (accept),
        .idx         (bank_addr),
        .idx_valid   (bank_rden)
    );

    // Metadata rides alongside the hash and the two bank stages.
    always_ff @(posedge clk) begin
        if (!stall) begin
            meta_s0 <= meta_in;
            meta_s1 <= meta_s0;
            meta_s2 <= meta_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1       <= 1'b0;
            valid_s2       <= 1'b0;
            meta_out_valid <= 1'b0;
        end else if (!stall) begin
            valid_s1       <= bank_rden;
            valid_s2       <= valid_s1;
            meta_out_valid <= valid_s2;
        end
    end

    // Lowest hitting bank wins; a miss gets the drop id.
    always_comb begin
        qid_sel = '1;
        for (int i = `FT_BANKS - 1; i >= 0; i--) begin
            hit[i] = bank_q[i].valid && (bank_q[i].tuple == meta_s2.tuple);
            if (hit[i]) begin
                qid_sel = bank_q[i].qid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && valid_s2) begin
            meta_out <= '{tuple: meta_s2.tuple, tag: meta_s2.tag, qid: qid_sel};
        end
    end

endmodule

`default_nettype wire

// File: rtl/flow_place_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_table_defs.svh"

module flow_place_fsm
    import flow_table_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  var ctrl_t            ctrl_in,
    input  wire                  ctrl_in_valid,
    output logic                 ctrl_in_ready,
    output logic                 ctrl_done,
    output logic                 ctrl_rejected,
    output logic [15:0]          reject_cnt,
    output bank_idx_t            bank_addr,
    output logic                 bank_rden,
    output logic [`FT_BANKS-1:0] bank_wren,
    output fce_t                 bank_wdata,
    input  var fce_t             bank_q [`FT_BANKS]
);

    place_state_t         state;
    logic                 busy;
    logic                 accept;
    logic                 idx_valid;
    logic [1:0]           rd_pipe;
    logic                 decide;
    logic [`FT_BANKS-1:0] hit;
    logic [`FT_BANKS-1:0] empty;
    logic [`FT_BANKS-1:0] wr_sel;

    function automatic logic [`FT_BANKS-1:0] lowest_one(input logic [`FT_BANKS-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    assign ctrl_in_ready = !busy;
    assign accept        = ctrl_in_valid && ctrl_in_ready;

    // Hash output stays put while a request is being served.
    flow_hash u_hash (
        .clk         (clk),
        .rst         (rst),
        .stall       (busy),
        .tuple       (ctrl_in.tuple),
        .tuple_valid (accept),
        .idx         (bank_addr),
        .idx_valid   (idx_valid)
    );

    // Reads only on a fresh hash, never in the done cycle.
    assign bank_rden = (state == P_IDLE) && busy && idx_valid && !ctrl_done;
    assign decide    = (state == P_READ) && rd_pipe[1];

    always_comb begin
        for (int i = 0; i < `FT_BANKS; i++) begin
            hit[i]   = bank_q[i].valid && (bank_q[i].tuple == bank_wdata.tuple);
            empty[i] = !bank_q[i].valid;
        end
    end

    // New entry, also the compare key for the read-back.
    always_ff @(posedge clk) begin
        if (accept) begin
            bank_wdata <= '{valid: 1'b1, tuple: ctrl_in.tuple, qid: ctrl_in.qid};
        end
    end

    // Update beats insert.
    always_ff @(posedge clk) begin
        if (decide) begin
            wr_sel <= (|hit) ? lowest_one(hit) : lowest_one(empty);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= P_IDLE;
            busy          <= 1'b0;
            rd_pipe       <= '0;
            bank_wren     <= '0;
            ctrl_done     <= 1'b0;
            ctrl_rejected <= 1'b0;
            reject_cnt    <= '0;
        end else begin
            rd_pipe   <= {rd_pipe[0], bank_rden};
            bank_wren <= '0;
            ctrl_done <= 1'b0;

            if (accept) begin
                busy <= 1'b1;
            end else if (ctrl_done) begin
                busy <= 1'b0;
            end

            case (state)
                P_IDLE: begin
                    if (bank_rden) begin
                        state <= P_READ;
                    end
                end
                P_READ: begin
                    // Bank data is back two cycles after the read.
                    if (decide) begin
                        if (|hit || |empty) begin
                            state <= P_WRITE;
                        end else begin
                            state <= P_REJECT;
                        end
                    end
                end
                P_WRITE: begin
                    bank_wren     <= wr_sel;
                    ctrl_done     <= 1'b1;
                    ctrl_rejected <= 1'b0;
                    state         <= P_IDLE;
                end
                P_REJECT: begin
                    ctrl_done     <= 1'b1;
                    ctrl_rejected <= 1'b1;
                    reject_cnt    <= reject_cnt + 1'b1;
                    state         <= P_IDLE;
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/flow_table_defs.svh
`ifndef FLOW_TABLE_DEFS_SVH
`define FLOW_TABLE_DEFS_SVH

// Field widths.
`define FT_TUPLE_W 32
`define FT_QID_W 8
`define FT_TAG_W 16

// Table geometry.
`define FT_BANKS 4
`define FT_AWIDTH 4
`define FT_DEPTH 16

// Multiplicative hash; bank i is seeded with i * FT_SEED_STEP.
`define FT_HASH_MULT 32'd2654435761
`define FT_SEED_STEP 32'h7f4a7c15

`endif

// File: rtl/flow_table_pkg.sv
`default_nettype none

`include "flow_table_defs.svh"

package flow_table_pkg;

    // One table entry.
    typedef struct packed {
        logic                   valid;
        logic [`FT_TUPLE_W-1:0] tuple;
        logic [`FT_QID_W-1:0]   qid;
    } fce_t;

    // Packet metadata; qid is filled in by the lookup.
    typedef struct packed {
        logic [`FT_TUPLE_W-1:0] tuple;
        logic [`FT_TAG_W-1:0]   tag;
        logic [`FT_QID_W-1:0]   qid;
    } meta_t;

    typedef struct packed {
        logic [`FT_TUPLE_W-1:0] tuple;
        logic [`FT_QID_W-1:0]   qid;
    } ctrl_t;

    typedef logic [`FT_BANKS-1:0][`FT_AWIDTH-1:0] bank_idx_t;

    typedef enum logic [1:0] {
        P_IDLE,
        P_READ,
        P_WRITE,
        P_REJECT
    } place_state_t;

endpackage

`default_nettype wire

// File: rtl/flow_table_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_table_defs.svh"

module flow_table_top
    import flow_table_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  var meta_t   meta_in,
    input  wire         meta_in_valid,
    output logic        meta_in_ready,
    output meta_t       meta_out,
    output logic        meta_out_valid,
    input  wire         meta_out_ready,
    input  var ctrl_t   ctrl_in,
    input  wire         ctrl_in_valid,
    output logic        ctrl_in_ready,
    output logic        ctrl_done,
    output logic        ctrl_rejected,
    output logic [15:0] reject_cnt
);

    // Port A side.
    bank_idx_t            lk_addr;
    logic                 lk_rden;
    logic                 lk_en;
    fce_t                 lk_q [`FT_BANKS];

    // Port B side.
    bank_idx_t            pl_addr;
    logic                 pl_rden;
    logic [`FT_BANKS-1:0] pl_wren;
    fce_t                 pl_wdata;
    fce_t                 pl_q [`FT_BANKS];

    flow_lookup u_lookup (
        .clk            (clk),
        .rst            (rst),
        .meta_in        (meta_in),
        .meta_in_valid  (meta_in_valid),
        .meta_in_ready  (meta_in_ready),
        .meta_out       (meta_out),
        .meta_out_valid (meta_out_valid),
        .meta_out_ready (meta_out_ready),
        .bank_addr      (lk_addr),
        .bank_rden      (lk_rden),
        .bank_en        (lk_en),
        .bank_q         (lk_q)
    );

    flow_place_fsm u_place (
        .clk           (clk),
        .rst           (rst),
        .ctrl_in       (ctrl_in),
        .ctrl_in_valid (ctrl_in_valid),
        .ctrl_in_ready (ctrl_in_ready),
        .ctrl_done     (ctrl_done),
        .ctrl_rejected (ctrl_rejected),
        .reject_cnt    (reject_cnt),
        .bank_addr     (pl_addr),
        .bank_rden     (pl_rden),
        .bank_wren     (pl_wren),
        .bank_wdata    (pl_wdata),
        .bank_q        (pl_q)
    );

    for (genvar i = 0; i < `FT_BANKS; i++) begin : g_bank
        flow_bank #(
            .AWIDTH (`FT_AWIDTH),
            .DEPTH  (`FT_DEPTH)
        ) u_bank (
            .clk    (clk),
            .addr_a (lk_addr[i]),
            .rden_a (lk_rden),
            .en_a   (lk_en),
            .q_a    (lk_q[i]),
            .addr_b (pl_addr[i]),
            .rden_b (pl_rden),
            .wren_b (pl_wren[i]),
            .data_b (pl_wdata),
            .q_b    (pl_q[i])
        );
    end

endmodule

`default_nettype wire

// File: tests/flow_table_checker.sv
`timescale 1ns/1ps
`default_nettype none

module flow_table_checker
    import flow_table_pkg::*;
(
    input wire       clk,
    input wire       rst,
    input var meta_t meta_out,
    input wire       meta_out_valid,
    input wire       meta_out_ready,
    input wire       ctrl_in_valid,
    input wire       ctrl_in_ready,
    input wire       ctrl_done
);

    int unsigned failures = 0;

    // Output frozen under back-pressure.
    assert property (@(posedge clk) disable iff (rst)
        meta_out_valid && !meta_out_ready |=> meta_out_valid && $stable(meta_out))
    else begin
        failures++;
        $error("meta_out changed while meta_out_ready was low");
    end

    assert property (@(posedge clk) disable iff (rst) ctrl_done |=> !ctrl_done)
    else begin
        failures++;
        $error("ctrl_done stayed high for more than one cycle");
    end

    // Ready low for the whole request, done on the fifth cycle.
    assert property (@(posedge clk) disable iff (rst)
        ctrl_in_valid && ctrl_in_ready |=> !ctrl_in_ready ##1 !ctrl_in_ready
            ##1 !ctrl_in_ready ##1 !ctrl_in_ready ##1 (!ctrl_in_ready && ctrl_done))
    else begin
        failures++;
        $error("ctrl_in_ready rose or ctrl_done was late during a request");
    end

    assert property (@(posedge clk) $fell(rst) |-> !meta_out_valid && !ctrl_done)
    else begin
        failures++;
        $error("valid or done asserted right after reset");
    end

endmodule

bind flow_table_top flow_table_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .meta_out       (meta_out),
    .meta_out_valid (meta_out_valid),
    .meta_out_ready (meta_out_ready),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_done      (ctrl_done)
);

`default_nettype wire

// File: tests/flow_table_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module flow_table_monitor
    import flow_table_pkg::*;
(
    input wire        clk,
    input wire        rst,
    input var meta_t  meta_out,
    input wire        meta_out_valid,
    input wire        meta_out_ready,
    input wire        ctrl_done,
    input wire        ctrl_rejected,
    input wire [15:0] reject_cnt
);

    meta_t       pkt_q [$];
    logic        rej_q [$];
    logic [15:0] cnt_q [$];
    meta_t       exp_pkt;
    logic        exp_rej;
    logic [15:0] exp_cnt;
    string       test_name = "none";
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          checks = 0;

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic expect_packet(input meta_t m);
        pkt_q.push_back(m);
    endtask

    task automatic expect_place(input logic rejected, input logic [15:0] count);
        rej_q.push_back(rejected);
        cnt_q.push_back(count);
    endtask

    task automatic note_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    function automatic int pending_packets();
        return pkt_q.size();
    endfunction

    task automatic finish_test();
        if (pkt_q.size() != 0) begin
            $display("%s: %0d packets never left the pipeline", test_name, pkt_q.size());
            test_errors++;
            pkt_q.delete();
        end
        if (rej_q.size() != 0) begin
            $display("%s: %0d requests never signalled done", test_name, rej_q.size());
            test_errors++;
            rej_q.delete();
            cnt_q.delete();
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("pass %s", test_name);
        end else begin
            tests_failed++;
            $display("fail %s with %0d errors", test_name, test_errors);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && meta_out_valid && meta_out_ready) begin
            checks++;
            if (pkt_q.size() == 0) begin
                note_failure($sformatf("packet with tag %h came out unexpected", meta_out.tag));
            end else begin
                exp_pkt = pkt_q.pop_front();
                if (meta_out !== exp_pkt) begin
                    $display("error %s expected %h actual %h", test_name, exp_pkt, meta_out);
                    test_errors++;
                end
            end
        end
        if (!rst && ctrl_done) begin
            checks++;
            if (rej_q.size() == 0) begin
                note_failure("done pulse without a pending request");
            end else begin
                exp_rej = rej_q.pop_front();
                exp_cnt = cnt_q.pop_front();
                if (ctrl_rejected !== exp_rej || reject_cnt !== exp_cnt) begin
                    $display("error %s expected rejected=%0b count=%0d actual rejected=%0b count=%0d",
                             test_name, exp_rej, exp_cnt, ctrl_rejected, reject_cnt);
                    test_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/flow_table_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_table_defs.svh"

module flow_table_tb
    import flow_table_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int N_MISS     = 16;
    localparam int N_INSERT   = 24;
    localparam int N_UPDATE   = 8;
    localparam int N_REJECT   = 5;
    localparam int N_BURST    = 32;
    localparam int TOTAL_REQ  = N_MISS + 2 * N_INSERT + 2 * N_UPDATE + 2 * N_REJECT + N_BURST;
    localparam int WATCHDOG_CYCLES = TOTAL_REQ * 40 + 200;

    logic        clk;
    logic        rst;
    meta_t       meta_in;
    logic        meta_in_valid;
    logic        meta_in_ready;
    meta_t       meta_out;
    logic        meta_out_valid;
    logic        meta_out_ready;
    ctrl_t       ctrl_in;
    logic        ctrl_in_valid;
    logic        ctrl_in_ready;
    logic        ctrl_done;
    logic        ctrl_rejected;
    logic [15:0] reject_cnt;

    fce_t        model_table [`FT_BANKS][`FT_DEPTH];
    int          model_rejects;
    logic [31:0] rand_state;
    logic [31:0] known [N_INSERT];
    logic [31:0] collide [N_REJECT];

    flow_table_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .meta_in        (meta_in),
        .meta_in_valid  (meta_in_valid),
        .meta_in_ready  (meta_in_ready),
        .meta_out       (meta_out),
        .meta_out_valid (meta_out_valid),
        .meta_out_ready (meta_out_ready),
        .ctrl_in        (ctrl_in),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_ready  (ctrl_in_ready),
        .ctrl_done      (ctrl_done),
        .ctrl_rejected  (ctrl_rejected),
        .reject_cnt     (reject_cnt)
    );

    flow_table_monitor u_mon (
        .clk            (clk),
        .rst            (rst),
        .meta_out       (meta_out),
        .meta_out_valid (meta_out_valid),
        .meta_out_ready (meta_out_ready),
        .ctrl_done      (ctrl_done),
        .ctrl_rejected  (ctrl_rejected),
        .reject_cnt     (reject_cnt)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Full product, low 32 bits kept, index from the top of those.
    function automatic logic [`FT_AWIDTH-1:0] hash_index(input logic [31:0] tuple,
                                                         input int bank);
        logic [31:0] seed;
        logic [63:0] product;
        seed    = bank * `FT_SEED_STEP;
        product = {32'd0, tuple ^ seed} * {32'd0, `FT_HASH_MULT};
        return product[31 -: `FT_AWIDTH];
    endfunction

    function automatic logic [7:0] model_lookup(input logic [31:0] tuple);
        fce_t e;
        for (int b = 0; b < `FT_BANKS; b++) begin
            e = model_table[b][hash_index(tuple, b)];
            if (e.valid && e.tuple == tuple) begin
                return e.qid;
            end
        end
        return 8'hff;
    endfunction

    // Update first, then lowest empty bank, else reject.
    function automatic logic model_place(input logic [31:0] tuple, input logic [7:0] qid);
        fce_t e;
        int target;
        target = -1;
        for (int b = `FT_BANKS - 1; b >= 0; b--) begin
            e = model_table[b][hash_index(tuple, b)];
            if (e.valid && e.tuple == tuple) begin
                target = b;
            end
        end
        for (int b = `FT_BANKS - 1; b >= 0 && target < 0; b--) begin
            if (!model_table[b][hash_index(tuple, b)].valid) begin
                target = b;
            end
        end
        if (target < 0) begin
            model_rejects++;
            return 1'b1;
        end
        model_table[target][hash_index(tuple, target)] = '{valid: 1'b1, tuple: tuple, qid: qid};
        return 1'b0;
    endfunction

    function automatic bit same_indices(input logic [31:0] a, input logic [31:0] b);
        for (int i = 0; i < `FT_BANKS; i++) begin
            if (hash_index(a, i) != hash_index(b, i)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic send_packet(input logic [31:0] tuple, input logic [15:0] tag,
                               input bit pressure);
        logic [31:0] r;
        bit accepted;
        u_mon.expect_packet('{tuple: tuple, tag: tag, qid: model_lookup(tuple)});
        meta_in       = '{tuple: tuple, tag: tag, qid: 8'h00};
        meta_in_valid = 1'b1;
        accepted      = 1'b0;
        while (!accepted) begin
            if (pressure) begin
                r = next_random();
                meta_out_ready = (r[29:28] != 2'b00);
            end
            @(posedge clk);
            accepted = meta_in_ready;
            @(negedge clk);
        end
        meta_in_valid = 1'b0;
    endtask

    task automatic place_flow(input logic [31:0] tuple, input logic [7:0] qid);
        logic rejected;
        int waited;
        rejected = model_place(tuple, qid);
        u_mon.expect_place(rejected, 16'(model_rejects));
        waited = 0;
        while (!ctrl_in_ready && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        ctrl_in       = '{tuple: tuple, qid: qid};
        ctrl_in_valid = 1'b1;
        @(negedge clk);
        ctrl_in_valid = 1'b0;
        waited = 0;
        while (!ctrl_done && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int cycles;
        meta_out_ready = 1'b1;
        cycles = 0;
        while (u_mon.pending_packets() != 0 && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        int found;
        int tries;
        rand_state    = 32'hf5d9b5f2;
        model_rejects = 0;
        for (int b = 0; b < `FT_BANKS; b++) begin
            for (int i = 0; i < `FT_DEPTH; i++) begin
                model_table[b][i] = '0;
            end
        end
        rst            = 1'b1;
        meta_in        = '0;
        meta_in_valid  = 1'b0;
        meta_out_ready = 1'b1;
        ctrl_in        = '0;
        ctrl_in_valid  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        u_mon.start_test("miss_empty");
        for (int i = 0; i < N_MISS; i++) begin
            r = next_random();
            send_packet(next_random(), r[31:16], 1'b0);
        end
        wait_drain();
        u_mon.finish_test();

        u_mon.start_test("insert_hit");
        for (int i = 0; i < N_INSERT; i++) begin
            known[i] = next_random();
            r = next_random();
            place_flow(known[i], r[23:16]);
        end
        for (int i = 0; i < N_INSERT; i++) begin
            r = next_random();
            send_packet(known[i], r[31:16], 1'b0);
        end
        wait_drain();
        u_mon.finish_test();

        u_mon.start_test("update");
        for (int i = 0; i < N_UPDATE; i++) begin
            place_flow(known[i], ~model_lookup(known[i]));
        end
        for (int i = 0; i < N_UPDATE; i++) begin
            r = next_random();
            send_packet(known[i], r[31:16], 1'b0);
        end
        wait_drain();
        u_mon.finish_test();

        // Random tuples that land on the same slot in every bank.
        u_mon.start_test("reject_full_set");
        collide[0] = next_random();
        found = 1;
        tries = 0;
        while (found < N_REJECT && tries < 4000000) begin
            r = next_random();
            if (same_indices(r, collide[0])) begin
                collide[found] = r;
                found++;
            end
            tries++;
        end
        if (found < N_REJECT) begin
            u_mon.note_failure("could not find enough tuples sharing one set");
        end
        for (int i = 0; i < found; i++) begin
            r = next_random();
            place_flow(collide[i], r[23:16]);
        end
        for (int i = 0; i < found; i++) begin
            r = next_random();
            send_packet(collide[i], r[31:16], 1'b0);
        end
        wait_drain();
        u_mon.finish_test();

        u_mon.start_test("back_pressure");
        for (int i = 0; i < N_BURST; i++) begin
            r = next_random();
            if (r[7]) begin
                send_packet(known[r[15:8] % N_INSERT], r[31:16], 1'b1);
            end else begin
                send_packet(next_random(), r[31:16], 1'b1);
            end
        end
        wait_drain();
        u_mon.finish_test();

        $display("summary: %0d run, %0d passed, %0d failed, %0d checks, %0d assertion failures",
                 u_mon.tests_passed + u_mon.tests_failed, u_mon.tests_passed,
                 u_mon.tests_failed, u_mon.checks, u_dut.u_checker.failures);
        if (u_mon.tests_failed == 0 && u_dut.u_checker.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
